//--- isa_pkg.sv
////////////////////////////////////////
// alpha subset isa definitions
// opcodes, function codes and the two
// instruction word formats
////////////////////////////////////////
package isa_pkg;

  ////////////////////////////////////////
  // primary opcodes, inst[31:26]
  ////////////////////////////////////////
  localparam logic [5:0] PAL_INST = 6'h00;
  localparam logic [5:0] LDA_INST = 6'h08;
  localparam logic [5:0] INTA_GRP = 6'h10;  // add, sub, compares
  localparam logic [5:0] INTL_GRP = 6'h11;  // logicals
  localparam logic [5:0] INTS_GRP = 6'h12;  // shifts
  localparam logic [5:0] INTM_GRP = 6'h13;  // multiply
  localparam logic [5:0] ITFP_GRP = 6'h14;
  localparam logic [5:0] FLTV_GRP = 6'h15;
  localparam logic [5:0] FLTI_GRP = 6'h16;
  localparam logic [5:0] FLTL_GRP = 6'h17;
  localparam logic [5:0] MISC_GRP = 6'h18;
  localparam logic [5:0] JSR_GRP  = 6'h1a;  // jmp, jsr, ret, jsr_co
  localparam logic [5:0] FTPI_GRP = 6'h1c;
  localparam logic [5:0] LDQ_INST = 6'h29;
  localparam logic [5:0] STQ_INST = 6'h2d;
  localparam logic [5:0] BR_INST  = 6'h30;
  localparam logic [5:0] FBEQ_INST = 6'h31;
  localparam logic [5:0] FBLT_INST = 6'h32;
  localparam logic [5:0] FBLE_INST = 6'h33;
  localparam logic [5:0] BSR_INST = 6'h34;
  localparam logic [5:0] FBNE_INST = 6'h35;
  localparam logic [5:0] FBGE_INST = 6'h36;
  localparam logic [5:0] FBGT_INST = 6'h37;

  ////////////////////////////////////////
  // operate function codes, inst[11:5]
  ////////////////////////////////////////
  localparam logic [6:0] ADDQ_INST   = 7'h20;
  localparam logic [6:0] SUBQ_INST   = 7'h29;
  localparam logic [6:0] CMPEQ_INST  = 7'h2d;
  localparam logic [6:0] CMPLT_INST  = 7'h4d;
  localparam logic [6:0] CMPLE_INST  = 7'h6d;
  localparam logic [6:0] CMPULT_INST = 7'h1d;
  localparam logic [6:0] CMPULE_INST = 7'h3d;
  localparam logic [6:0] AND_INST    = 7'h00;
  localparam logic [6:0] BIC_INST    = 7'h08;
  localparam logic [6:0] BIS_INST    = 7'h20;
  localparam logic [6:0] ORNOT_INST  = 7'h28;
  localparam logic [6:0] XOR_INST    = 7'h40;
  localparam logic [6:0] EQV_INST    = 7'h48;
  localparam logic [6:0] SRL_INST    = 7'h34;
  localparam logic [6:0] SLL_INST    = 7'h39;
  localparam logic [6:0] SRA_INST    = 7'h3c;
  localparam logic [6:0] MULQ_INST   = 7'h20;

  localparam logic [25:0] HALT_CODE = 26'h0555;  // pal function for halt
  localparam logic [4:0]  ZERO_REG  = 5'd31;     // r31 reads as zero

  // operate format
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] ra;
    logic [4:0] rb;      // top of the literal when is_lit
    logic [2:0] sbz_lit; // should be zero in register form
    logic       is_lit;
    logic [6:0] func;
    logic [4:0] rc;
  } operate_fmt_t;

  // memory and branch format
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [15:0] disp;
  } memory_fmt_t;

  typedef union packed {
    operate_fmt_t op;
    memory_fmt_t  mem;
  } inst_word_u;

endpackage

//--- id_pkg.sv
////////////////////////////////////////
// decode stage control types
// mux selects, alu functions and the
// registered pair handed to execute
////////////////////////////////////////
package id_pkg;
  import isa_pkg::*;

  localparam int unsigned COUNT_W = 32;  // instruction tally width

  typedef enum logic [1:0] {
    OPA_IS_REGA     = 2'd0,
    OPA_IS_NPC      = 2'd1,
    OPA_IS_NOT3     = 2'd2,  // mask for jump target alignment
    OPA_IS_MEM_DISP = 2'd3
  } opa_sel_e;

  typedef enum logic [1:0] {
    OPB_IS_REGB    = 2'd0,
    OPB_IS_ALU_IMM = 2'd1,
    OPB_IS_BR_DISP = 2'd2
  } opb_sel_e;

  typedef enum logic [4:0] {
    ALU_ADDQ, ALU_SUBQ,
    ALU_CMPEQ, ALU_CMPLT, ALU_CMPLE, ALU_CMPULT, ALU_CMPULE,
    ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT, ALU_XOR, ALU_EQV,
    ALU_SRL, ALU_SLL, ALU_SRA,
    ALU_MULQ
  } alu_func_e;

  // decoder internal, picks the dest index
  typedef enum logic [1:0] {
    DEST_NONE    = 2'd0,
    DEST_IS_REGA = 2'd1,
    DEST_IS_REGC = 2'd2
  } dest_sel_e;

  typedef struct packed {
    opa_sel_e   opa_sel;
    opb_sel_e   opb_sel;
    alu_func_e  alu_func;
    logic [4:0] dest_idx;       // ZERO_REG when nothing is written
    logic [4:0] ra_idx;         // to the map table
    logic [4:0] rb_idx;
    logic       rd_mem;
    logic       wr_mem;
    logic       cond_branch;
    logic       uncond_branch;
    logic       halt;
    logic       illegal;
    logic       valid_inst;     // counted for cpi
  } id_ctrl_t;

  typedef struct packed {
    id_ctrl_t slot_0;  // older instruction
    id_ctrl_t slot_1;
  } id_pair_t;

  // bubble
  localparam id_ctrl_t ID_NOOP = '{
    opa_sel:       OPA_IS_REGA,
    opb_sel:       OPB_IS_REGB,
    alu_func:      ALU_ADDQ,
    dest_idx:      ZERO_REG,
    ra_idx:        ZERO_REG,
    rb_idx:        ZERO_REG,
    rd_mem:        1'b0,
    wr_mem:        1'b0,
    cond_branch:   1'b0,
    uncond_branch: 1'b0,
    halt:          1'b0,
    illegal:       1'b0,
    valid_inst:    1'b0
  };

endpackage

//--- inst_decoder.sv
////////////////////////////////////////
// one decode slot
// instruction word in, datapath controls
// and register indices out, no state
////////////////////////////////////////
module inst_decoder (
  input  isa_pkg::inst_word_u inst,
  input  logic                inst_valid,  // low gives a bubble
  output id_pkg::id_ctrl_t    ctrl
);
  import isa_pkg::*;
  import id_pkg::*;

  opa_sel_e    opa_sel;
  opb_sel_e    opb_sel;
  alu_func_e   alu_func;
  dest_sel_e   dest_sel;
  logic [4:0]  dest_idx;
  logic [25:0] pal_func;
  logic        rd_mem;
  logic        wr_mem;
  logic        cond_br;
  logic        uncond_br;
  logic        halt;
  logic        illegal;

  assign pal_func = {inst.mem.ra, inst.mem.rb, inst.mem.disp};  // whole low 26 bits

  ////////////////////////////////////////
  // group decode on inst[31:29]
  ////////////////////////////////////////
  always_comb
  begin
    opa_sel   = OPA_IS_REGA;
    opb_sel   = OPB_IS_REGB;
    alu_func  = ALU_ADDQ;
    dest_sel  = DEST_NONE;
    rd_mem    = 1'b0;
    wr_mem    = 1'b0;
    cond_br   = 1'b0;
    uncond_br = 1'b0;
    halt      = 1'b0;
    illegal   = 1'b0;
    case (inst.op.opcode[5:3])
      3'b000:  // pal space, only halt is decoded
      begin
        if (inst.op.opcode == PAL_INST && pal_func == HALT_CODE)
          halt = 1'b1;
        else
          illegal = 1'b1;
      end
      3'b010:
      begin
        opb_sel  = inst.op.is_lit ? OPB_IS_ALU_IMM : OPB_IS_REGB;
        dest_sel = DEST_IS_REGC;
        case (inst.op.opcode)
          INTA_GRP:
            case (inst.op.func)
              ADDQ_INST:   alu_func = ALU_ADDQ;
              SUBQ_INST:   alu_func = ALU_SUBQ;
              CMPEQ_INST:  alu_func = ALU_CMPEQ;
              CMPLT_INST:  alu_func = ALU_CMPLT;
              CMPLE_INST:  alu_func = ALU_CMPLE;
              CMPULT_INST: alu_func = ALU_CMPULT;
              CMPULE_INST: alu_func = ALU_CMPULE;
              default:     illegal  = 1'b1;
            endcase
          INTL_GRP:
            case (inst.op.func)
              AND_INST:   alu_func = ALU_AND;
              BIC_INST:   alu_func = ALU_BIC;
              BIS_INST:   alu_func = ALU_BIS;
              ORNOT_INST: alu_func = ALU_ORNOT;
              XOR_INST:   alu_func = ALU_XOR;
              EQV_INST:   alu_func = ALU_EQV;
              default:    illegal  = 1'b1;
            endcase
          INTS_GRP:
            case (inst.op.func)
              SRL_INST: alu_func = ALU_SRL;
              SLL_INST: alu_func = ALU_SLL;
              SRA_INST: alu_func = ALU_SRA;
              default:  illegal  = 1'b1;
            endcase
          INTM_GRP:
            if (inst.op.func == MULQ_INST)
              alu_func = ALU_MULQ;
            else
              illegal = 1'b1;
          ITFP_GRP, FLTV_GRP, FLTI_GRP, FLTL_GRP: illegal = 1'b1;  // no fp unit
          default: illegal = 1'b1;
        endcase
      end
      3'b011:
      begin
        case (inst.op.opcode)
          JSR_GRP:  // jmp/jsr/ret/jsr_co all behave alike
          begin
            opa_sel   = OPA_IS_NOT3;
            alu_func  = ALU_AND;      // word align the target
            dest_sel  = DEST_IS_REGA; // return address
            uncond_br = 1'b1;
          end
          MISC_GRP, FTPI_GRP: illegal = 1'b1;
          default:            illegal = 1'b1;
        endcase
      end
      3'b001, 3'b100, 3'b101:  // memory format, ea = rb + disp
      begin
        opa_sel = OPA_IS_MEM_DISP;
        case (inst.op.opcode)
          LDA_INST: dest_sel = DEST_IS_REGA;  // address only, no access
          LDQ_INST:
          begin
            rd_mem   = 1'b1;
            dest_sel = DEST_IS_REGA;
          end
          STQ_INST: wr_mem  = 1'b1;
          default:  illegal = 1'b1;
        endcase
      end
      3'b110, 3'b111:  // branch format, target = npc + disp
      begin
        opa_sel = OPA_IS_NPC;
        opb_sel = OPB_IS_BR_DISP;
        case (inst.op.opcode)
          FBEQ_INST, FBLT_INST, FBLE_INST,
          FBNE_INST, FBGE_INST, FBGT_INST: illegal = 1'b1;
          BR_INST, BSR_INST:
          begin
            dest_sel  = DEST_IS_REGA;  // link
            uncond_br = 1'b1;
          end
          default: cond_br = 1'b1;     // integer conditionals
        endcase
      end
    endcase
  end

  always_comb
  begin
    case (dest_sel)
      DEST_IS_REGA: dest_idx = inst.mem.ra;
      DEST_IS_REGC: dest_idx = inst.op.rc;
      default:      dest_idx = ZERO_REG;
    endcase
  end

  ////////////////////////////////////////
  // output assembly
  ////////////////////////////////////////
  always_comb
  begin
    ctrl = ID_NOOP;
    if (inst_valid)
    begin
      ctrl.ra_idx     = inst.mem.ra;
      ctrl.rb_idx     = inst.mem.rb;
      ctrl.halt       = halt;
      ctrl.illegal    = illegal;
      ctrl.valid_inst = !illegal && !halt;  // halts are not counted
      if (!illegal)                         // illegal words keep noop controls
      begin
        ctrl.opa_sel       = opa_sel;
        ctrl.opb_sel       = opb_sel;
        ctrl.alu_func      = alu_func;
        ctrl.dest_idx      = dest_idx;
        ctrl.rd_mem        = rd_mem;
        ctrl.wr_mem        = wr_mem;
        ctrl.cond_branch   = cond_br;
        ctrl.uncond_branch = uncond_br;
      end
    end
  end

  // execute resolves at most one of these per slot
  always_comb
  begin
    assert ($onehot0({ctrl.halt, ctrl.illegal, ctrl.cond_branch, ctrl.uncond_branch}))
      else $error("decode slot raised halt, illegal and branch together");
  end

endmodule

//--- halt_ctrl.sv
////////////////////////////////////////
// run/halted state machine
// builds the fetch accept handshake
////////////////////////////////////////
module halt_ctrl (
  input  logic       clock,
  input  logic       rst_n,
  input  logic       if_valid,
  input  logic [1:0] halt_slot,     // decoded halt per slot
  input  logic       id_valid,
  input  logic       ex_ready,
  output logic       if_ready,
  output logic       load_en,       // output register load
  output logic       squash_slot1   // slot 1 sits behind a halt
);

  typedef enum logic {
    RUN,
    HALTED
  } state_e;

  state_e state;
  state_e state_nxt;

  // room when the output reg is empty or draining
  assign if_ready     = (state == RUN) && (!id_valid || ex_ready);
  assign load_en      = if_valid && if_ready;
  assign squash_slot1 = halt_slot[0];

  always_comb
  begin
    state_nxt = state;
    if (load_en && |halt_slot)
      state_nxt = HALTED;  // only reset leaves
  end

  always_ff @(posedge clock)
  begin
    if (!rst_n)
      state <= RUN;
    else
      state <= state_nxt;
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  halt_stop_a: assert property (@(posedge clock) disable iff (!rst_n)
    load_en && |halt_slot |=> !if_ready)
    else $error("fetch still accepted after a halting pair");

  halted_sticky_a: assert property (@(posedge clock) disable iff (!rst_n)
    state == HALTED |=> state == HALTED && !if_ready)
    else $error("stage left halted or reopened intake");

endmodule

//--- inst_counter.sv
////////////////////////////////////////
// valid instruction tally for cpi
////////////////////////////////////////
module inst_counter (
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic                       load_en,
  input  logic [1:0]                 slot_valid,  // post-squash valid_inst
  output logic [id_pkg::COUNT_W-1:0] inst_count
);
  import id_pkg::*;

  logic [COUNT_W-1:0] inc;  // 0, 1 or 2

  assign inc = COUNT_W'(slot_valid[0]) + COUNT_W'(slot_valid[1]);

  always_ff @(posedge clock)
  begin
    if (!rst_n)
      inst_count <= '0;
    else if (load_en)
      inst_count <= inst_count + inc;  // wraps at full width
  end

endmodule

//--- id_stage.sv
////////////////////////////////////////
// two wide instruction decode stage
// decodes a fetched pair and holds it
// until execute takes it
////////////////////////////////////////
module id_stage (
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic                       if_valid,
  input  isa_pkg::inst_word_u [1:0]  if_inst,        // [0] is older
  input  logic [1:0]                 if_inst_valid,
  output logic                       if_ready,
  output logic                       id_valid,
  output id_pkg::id_pair_t           id_pair,
  input  logic                       ex_ready,
  output logic [id_pkg::COUNT_W-1:0] inst_count
);
  import id_pkg::*;

  id_ctrl_t ctrl_0;
  id_ctrl_t ctrl_1;
  id_ctrl_t ctrl_1_fin;    // after halt squash
  logic     load_en;
  logic     squash_slot1;

  inst_decoder decoder_0 (
    .inst       (if_inst[0]),
    .inst_valid (if_inst_valid[0]),
    .ctrl       (ctrl_0)
  );

  inst_decoder decoder_1 (
    .inst       (if_inst[1]),
    .inst_valid (if_inst_valid[1]),
    .ctrl       (ctrl_1)
  );

  assign ctrl_1_fin = squash_slot1 ? ID_NOOP : ctrl_1;  // nothing issues past a halt

  halt_ctrl halt_ctrl_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .if_valid     (if_valid),
    .halt_slot    ({ctrl_1.halt, ctrl_0.halt}),
    .id_valid     (id_valid),
    .ex_ready     (ex_ready),
    .if_ready     (if_ready),
    .load_en      (load_en),
    .squash_slot1 (squash_slot1)
  );

  inst_counter inst_counter_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .load_en    (load_en),
    .slot_valid ({ctrl_1_fin.valid_inst, ctrl_0.valid_inst}),
    .inst_count (inst_count)
  );

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (!rst_n)
      id_valid <= 1'b0;
    else if (load_en)
      id_valid <= 1'b1;
    else if (ex_ready)
      id_valid <= 1'b0;  // drained, nothing new
  end

  always_ff @(posedge clock)
  begin
    if (load_en)
      id_pair <= '{slot_0: ctrl_0, slot_1: ctrl_1_fin};
  end

  // execute sees a stable pair across a stall
  hold_a: assert property (@(posedge clock) disable iff (!rst_n)
    id_valid && !ex_ready |=> id_valid && $stable(id_pair))
    else $error("output pair changed while execute stalled");

endmodule

//--- id_stage_tb.sv
////////////////////////////////////////
// decode stage testbench
// replays vector pairs under random
// execute stalls and checks every pair
////////////////////////////////////////
module id_stage_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import isa_pkg::*;
  import id_pkg::*;

  localparam int WAIT_LIMIT    = 200;  // cycles per wait loop
  localparam int REFUSE_CYCLES = 20;   // intake must stay shut this long

  typedef struct packed {
    id_pair_t           pair;
    logic [COUNT_W-1:0] count;  // running tally after this pair
  } expect_t;

  logic               clock;
  logic               rst_n;
  logic               if_valid;
  inst_word_u [1:0]   if_inst;
  logic [1:0]         if_inst_valid;
  logic               if_ready;
  logic               id_valid;
  id_pair_t           id_pair;
  logic               ex_ready;
  logic [COUNT_W-1:0] inst_count;

  logic [31:0] fld [0:18];  // one parsed vector line
  logic [31:0] lcg_state;
  expect_t     exp_q [$];   // accepted but not yet delivered

  id_stage dut_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .if_valid      (if_valid),
    .if_inst       (if_inst),
    .if_inst_valid (if_inst_valid),
    .if_ready      (if_ready),
    .id_valid      (id_valid),
    .id_pair       (id_pair),
    .ex_ready      (ex_ready),
    .inst_count    (inst_count)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "decode stage run aborted");
  endtask

  task automatic check_ctrl(input id_ctrl_t got, input id_ctrl_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("error at %0d ns: %s controls %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_count(input logic [COUNT_W-1:0] got, input logic [COUNT_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("error at %0d ns: inst_count %0d, expected %0d", $time, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // seven columns per slot starting at base
  function automatic id_ctrl_t ctrl_from_fields(input logic [4:0] base);
    id_ctrl_t c;
    c.opa_sel  = opa_sel_e'(fld[base][1:0]);
    c.opb_sel  = opb_sel_e'(fld[base + 5'd1][1:0]);
    c.alu_func = alu_func_e'(fld[base + 5'd2][4:0]);
    c.dest_idx = fld[base + 5'd3][4:0];
    c.ra_idx   = fld[base + 5'd4][4:0];
    c.rb_idx   = fld[base + 5'd5][4:0];
    {c.rd_mem, c.wr_mem, c.cond_branch, c.uncond_branch, c.halt, c.illegal, c.valid_inst}
      = fld[base + 5'd6][6:0];
    return c;
  endfunction

  initial
  begin : clock_gen
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // execute side stalls about one cycle in four
  initial
  begin : backpressure
    ex_ready  = 1'b1;
    lcg_state = 32'hcde2454c;
    forever
    begin
      @(posedge clock);
      #1;
      lcg_state = lcg_next(lcg_state);
      ex_ready  = (lcg_state[31:30] != 2'b00);
    end
  end

  ////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////
  initial
  begin : monitor
    expect_t exp;
    forever
    begin
      @(posedge clock);
      if (rst_n && id_valid && ex_ready)  // transfer on this edge
      begin
        if (exp_q.size() == 0)
          abort_run("the stage delivered a pair that was never accepted");
        exp = exp_q.pop_front();
        check_ctrl(id_pair.slot_0, exp.pair.slot_0, "slot 0");
        check_ctrl(id_pair.slot_1, exp.pair.slot_1, "slot 1");
        check_count(inst_count, exp.count);
      end
    end
  end

  ////////////////////////////////////////
  // fetch side stimulus
  ////////////////////////////////////////
  initial
  begin : stimulus
    int      fd;
    int      n;
    int      waited;
    logic    halted;
    string   line;
    expect_t exp;

    rst_n         = 1'b0;
    if_valid      = 1'b0;
    if_inst       = '0;
    if_inst_valid = 2'b00;
    halted        = 1'b0;
    fd = $fopen("decode_input.txt", "r");
    if (fd == 0)
      abort_run("could not open decode_input.txt");

    repeat (5) @(posedge clock);
    #1;
    rst_n = 1'b1;
    check_flag(id_valid, 1'b0, "id_valid after reset");
    check_flag(if_ready, 1'b1, "if_ready after reset");
    check_count(inst_count, '0);

    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 4 || line.getc(0) == "#")
        continue;  // comment or blank
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                  fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                  fld[15], fld[16], fld[17], fld[18]);
      if (n != 19)
        abort_run({"malformed vector line: ", line});
      exp.pair.slot_0 = ctrl_from_fields(5'd4);
      exp.pair.slot_1 = ctrl_from_fields(5'd11);
      exp.count       = fld[18];
      if_valid      = 1'b1;
      if_inst[0]    = fld[0];
      if_inst[1]    = fld[1];
      if_inst_valid = {fld[3][0], fld[2][0]};
      if (halted)
      begin
        // only reset reopens intake
        repeat (REFUSE_CYCLES)
        begin
          @(posedge clock);
          check_flag(if_ready, 1'b0, "if_ready after halt");
        end
      end
      else
      begin
        waited = 0;
        @(posedge clock);
        while (!if_ready)
        begin
          waited++;
          if (waited >= WAIT_LIMIT)
            abort_run("the stage stalled, a fetch pair was not accepted in 200 cycles");
          @(posedge clock);
        end
        exp_q.push_back(exp);  // accepted on this edge
        if (exp.pair.slot_0.halt || exp.pair.slot_1.halt)
          halted = 1'b1;
      end
      #1;
    end
    $fclose(fd);
    if_valid      = 1'b0;
    if_inst_valid = 2'b00;

    waited = 0;  // let execute drain the last pair
    while (exp_q.size() != 0 && waited < WAIT_LIMIT)
    begin
      @(posedge clock);
      waited++;
    end
    #1;
    if (exp_q.size() == 0)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
      abort_run("the stage stalled, accepted pairs were never delivered");
  end

endmodule

//--- decode_input.txt
# w0 w1 v0 v1, then per slot: opa opb alu dest ra rb flags, then count (all hex)
# flags = {rd_mem wr_mem cond_br uncond_br halt illegal valid_inst}
40220403 40220523 1 1  0 0 00 03 01 02 01  0 0 01 03 01 02 01  00000002
402205a3 402219a3 1 1  0 0 02 03 01 02 01  0 1 03 03 01 02 01  00000004
40221da3 402203a3 1 1  0 1 04 03 01 02 01  0 0 05 03 01 02 01  00000006
402207a3 40221403 1 1  0 0 06 03 01 02 01  0 1 00 03 01 02 01  00000008
44220003 44221103 1 1  0 0 07 03 01 02 01  0 1 08 03 01 02 01  0000000a
44220403 44220503 1 1  0 0 09 03 01 02 01  0 0 0a 03 01 02 01  0000000c
44221803 44220903 1 1  0 1 0b 03 01 02 01  0 0 0c 03 01 02 01  0000000e
48220683 48221723 1 1  0 0 0d 03 01 02 01  0 1 0e 03 01 02 01  00000010
48221783 4c220403 1 1  0 1 0f 03 01 02 01  0 0 10 03 01 02 01  00000012
4c221403 40221523 1 1  0 1 10 03 01 02 01  0 1 01 03 01 02 01  00000014
40e80409 20850010 1 1  0 0 00 09 07 08 01  3 0 00 04 04 05 01  00000016
a4850010 b4850010 1 1  3 0 00 04 04 05 41  3 0 00 1f 04 05 21  00000018
c35f0004 d35f0004 1 1  1 2 00 1a 1a 1f 09  1 2 00 1a 1a 1f 09  0000001a
e4c00008 6b5b4000 1 1  1 2 00 1f 06 00 11  2 0 07 1a 1a 1b 09  0000001c
50220003 60220000 1 1  0 0 00 1f 01 02 02  0 0 00 1f 01 02 02  0000001c
40220fe3 c4220000 1 1  0 0 00 1f 01 02 02  0 0 00 1f 01 02 02  0000001c
00000083 04220000 1 1  0 0 00 1f 00 00 02  0 0 00 1f 01 02 02  0000001c
40220403 44220003 1 0  0 0 00 03 01 02 01  0 0 00 1f 1f 1f 00  0000001d
00000555 40220403 0 0  0 0 00 1f 1f 1f 00  0 0 00 1f 1f 1f 00  0000001d
00000555 44220403 0 1  0 0 00 1f 1f 1f 00  0 0 09 03 01 02 01  0000001e
402215a3 f4c00008 1 1  0 1 02 03 01 02 01  1 2 00 1f 06 00 11  00000020
00000555 40220403 1 1  0 0 00 1f 00 00 04  0 0 00 1f 1f 1f 00  00000020
40220403 40220523 1 1  0 0 00 03 01 02 01  0 0 01 03 01 02 01  00000022
a4850010 b4850010 1 1  3 0 00 04 04 05 41  3 0 00 1f 04 05 21  00000024

//--- files.f
isa_pkg.sv
id_pkg.sv
inst_decoder.sv
halt_ctrl.sv
inst_counter.sv
id_stage.sv
id_stage_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module id_stage_tb -o id_stage_sim &&
./obj_dir/id_stage_sim ||
{ echo "simulation failed"; exit 1; }
